// ==== verilog/cbuf_pkg.sv ====
// ===================================================================
// convolution buffer definitions
// bank geometry, pipeline depths, word types and port structs
// ===================================================================
package cbuf_pkg;

  // ===================================================================
  // geometry
  // ===================================================================
  // one ram per bank, 16 rows of one word each
  localparam int cbuf_bank_num  = 16;
  localparam int cbuf_bank_bits = 4;
  localparam int cbuf_row_bits  = 4;
  // bank field sits above the row field
  localparam int cbuf_addr_bits = cbuf_bank_bits + cbuf_row_bits;
  localparam int cbuf_word_bits = 32;

  // ===================================================================
  // pipeline depths
  // ===================================================================
  // register levels of the bank output or-tree
  localparam int cbuf_merge_stages = 4;
  // request to response, decode + ram + merge tree
  localparam int cbuf_rd_latency   = 6;
  // inputs per or-tree node
  localparam int cbuf_merge_fanin  = 4;

  typedef logic [cbuf_addr_bits-1:0] cbuf_addr_t;
  typedef logic [cbuf_bank_bits-1:0] cbuf_bank_t;
  typedef logic [cbuf_row_bits-1:0]  cbuf_row_t;
  typedef logic [cbuf_word_bits-1:0] cbuf_word_t;
  // one bit per bank, used for enables and read hits
  typedef logic [cbuf_bank_num-1:0]  cbuf_bank_mask_t;

  // write request, data port 0 or weight port 1
  typedef struct packed {
    logic       en;
    cbuf_addr_t addr;
    cbuf_word_t data;
  } cbuf_wr_req_t;

  typedef struct packed {
    logic       en;
    cbuf_addr_t addr;
  } cbuf_rd_req_t;

  typedef struct packed {
    logic       valid;
    cbuf_word_t data;
  } cbuf_rd_rsp_t;

  // bank side write and read controls
  typedef struct packed {
    logic       en;
    cbuf_row_t  row;
    cbuf_word_t data;
  } cbuf_ram_wr_t;

  typedef struct packed {
    logic      en;
    cbuf_row_t row;
  } cbuf_ram_rd_t;

endpackage

// ==== verilog/cbuf_bank_ram.sv ====
// ===================================================================
// convolution buffer bank
// one write port and one registered read port
// ===================================================================
module cbuf_bank_ram
  import cbuf_pkg::*;
(
  input  logic         nvdla_core_clk,
  input  cbuf_ram_wr_t wr,
  input  cbuf_ram_rd_t rd,
  output cbuf_word_t   rd_data
);

  // storage array, one word per row
  cbuf_word_t mem [2**cbuf_row_bits];

  // write side
  always_ff @(posedge nvdla_core_clk) begin
    if (wr.en) begin
      mem[wr.row] <= wr.data;
    end
  end

  // read side, output register holds until the next read
  // same row read and write in one cycle returns the old word
  always_ff @(posedge nvdla_core_clk) begin
    if (rd.en) begin
      rd_data <= mem[rd.row];
    end
  end

endmodule

// ==== verilog/cbuf_write_path.sv ====
// ===================================================================
// convolution buffer write path
// bank decode of both write ports, port 0 priority, two pipe stages
// ===================================================================
module cbuf_write_path
  import cbuf_pkg::*;
(
  input  logic         nvdla_core_clk,
  input  logic         rst,
  input  cbuf_wr_req_t dat_wr,
  input  cbuf_wr_req_t wt_wr,
  output cbuf_ram_wr_t ram_wr [cbuf_bank_num]
);

  // bank field of each port
  cbuf_bank_t      dat_bank;
  cbuf_bank_t      wt_bank;
  // per-bank enables, decode stage
  cbuf_bank_mask_t dat_en_d0;
  cbuf_bank_mask_t wt_en_d0;
  // stage 1, per port
  cbuf_bank_mask_t dat_en_d1;
  cbuf_bank_mask_t wt_en_d1;
  cbuf_addr_t      dat_addr_d1;
  cbuf_addr_t      wt_addr_d1;
  cbuf_word_t      dat_data_d1;
  cbuf_word_t      wt_data_d1;
  // per-bank pick from the winning port
  cbuf_bank_mask_t bank_en_d1;
  cbuf_row_t       bank_row_d1 [cbuf_bank_num];
  cbuf_word_t      bank_data_d1 [cbuf_bank_num];
  // stage 2, per bank
  cbuf_bank_mask_t bank_en_d2;
  cbuf_row_t       bank_row_d2 [cbuf_bank_num];
  cbuf_word_t      bank_data_d2 [cbuf_bank_num];

  // ===================================================================
  // bank decode
  // ===================================================================
  assign dat_bank = dat_wr.addr[cbuf_addr_bits-1 -: cbuf_bank_bits];
  assign wt_bank  = wt_wr.addr[cbuf_addr_bits-1 -: cbuf_bank_bits];

  // weight write is dropped on a bank the data port also hits
  always_comb begin
    dat_en_d0 = dat_wr.en ? (cbuf_bank_mask_t'(1) << dat_bank) : '0;
    wt_en_d0  = (wt_wr.en ? (cbuf_bank_mask_t'(1) << wt_bank) : '0) & ~dat_en_d0;
  end

  // ===================================================================
  // stage 1
  // ===================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      dat_en_d1 <= '0;
      wt_en_d1  <= '0;
    end else begin
      dat_en_d1 <= dat_en_d0;
      wt_en_d1  <= wt_en_d0;
    end
  end

  // payload only loads with a request
  always_ff @(posedge nvdla_core_clk) begin
    if (dat_wr.en) begin
      dat_addr_d1 <= dat_wr.addr;
      dat_data_d1 <= dat_wr.data;
    end
    if (wt_wr.en) begin
      wt_addr_d1 <= wt_wr.addr;
      wt_data_d1 <= wt_wr.data;
    end
  end

  // at most one port enabled per bank here, data port checked first
  always_comb begin
    bank_en_d1 = dat_en_d1 | wt_en_d1;
    for (int b = 0; b < cbuf_bank_num; b++) begin
      if (dat_en_d1[b]) begin
        bank_row_d1[b]  = dat_addr_d1[cbuf_row_bits-1:0];
        bank_data_d1[b] = dat_data_d1;
      end else begin
        bank_row_d1[b]  = wt_addr_d1[cbuf_row_bits-1:0];
        bank_data_d1[b] = wt_data_d1;
      end
    end
  end

  // ===================================================================
  // stage 2, registered into the rams
  // ===================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      bank_en_d2 <= '0;
    end else begin
      bank_en_d2 <= bank_en_d1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_bank_num; b++) begin
      if (bank_en_d1[b]) begin
        bank_row_d2[b]  <= bank_row_d1[b];
        bank_data_d2[b] <= bank_data_d1[b];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < cbuf_bank_num; b++) begin
      ram_wr[b].en   = bank_en_d2[b];
      ram_wr[b].row  = bank_row_d2[b];
      ram_wr[b].data = bank_data_d2[b];
    end
  end

endmodule

// ==== verilog/cbuf_read_decode.sv ====
// ===================================================================
// convolution buffer read decode
// bank decode of both read ports, per-bank read request, hit pipeline
// ===================================================================
module cbuf_read_decode
  import cbuf_pkg::*;
(
  input  logic            nvdla_core_clk,
  input  logic            rst,
  input  cbuf_rd_req_t    dat_rd,
  input  cbuf_rd_req_t    wt_rd,
  output cbuf_ram_rd_t    ram_rd [cbuf_bank_num],
  output cbuf_bank_mask_t dat_hit,
  output cbuf_bank_mask_t wt_hit
);

  // bank and row fields of each port
  cbuf_bank_t      dat_bank;
  cbuf_bank_t      wt_bank;
  cbuf_row_t       dat_row;
  cbuf_row_t       wt_row;
  // one-hot bank hits, decode stage
  cbuf_bank_mask_t dat_hit_d0;
  cbuf_bank_mask_t wt_hit_d0;
  // per-bank read request
  cbuf_bank_mask_t rd_en_d0;
  cbuf_row_t       rd_row_d0 [cbuf_bank_num];
  cbuf_bank_mask_t rd_en_d1;
  cbuf_row_t       rd_row_d1 [cbuf_bank_num];
  // hit delay line, one stage for the request reg and one for the ram
  cbuf_bank_mask_t dat_hit_q [cbuf_rd_latency-cbuf_merge_stages];
  cbuf_bank_mask_t wt_hit_q [cbuf_rd_latency-cbuf_merge_stages];

  // ===================================================================
  // decode
  // ===================================================================
  assign dat_bank = dat_rd.addr[cbuf_addr_bits-1 -: cbuf_bank_bits];
  assign wt_bank  = wt_rd.addr[cbuf_addr_bits-1 -: cbuf_bank_bits];
  assign dat_row  = dat_rd.addr[cbuf_row_bits-1:0];
  assign wt_row   = wt_rd.addr[cbuf_row_bits-1:0];

  // ports never share a bank in one cycle, so the row pick is clean
  always_comb begin
    dat_hit_d0 = dat_rd.en ? (cbuf_bank_mask_t'(1) << dat_bank) : '0;
    wt_hit_d0  = wt_rd.en ? (cbuf_bank_mask_t'(1) << wt_bank) : '0;
    rd_en_d0   = dat_hit_d0 | wt_hit_d0;
    for (int b = 0; b < cbuf_bank_num; b++) begin
      rd_row_d0[b] = dat_hit_d0[b] ? dat_row : wt_row;
    end
  end

  // ===================================================================
  // read request register
  // ===================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      rd_en_d1 <= '0;
    end else begin
      rd_en_d1 <= rd_en_d0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_bank_num; b++) begin
      if (rd_en_d0[b]) begin
        rd_row_d1[b] <= rd_row_d0[b];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < cbuf_bank_num; b++) begin
      ram_rd[b].en  = rd_en_d1[b];
      ram_rd[b].row = rd_row_d1[b];
    end
  end

  // hit pipeline, last stage lines up with the ram output register
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      for (int i = 0; i < cbuf_rd_latency - cbuf_merge_stages; i++) begin
        dat_hit_q[i] <= '0;
        wt_hit_q[i]  <= '0;
      end
    end else begin
      dat_hit_q[0] <= dat_hit_d0;
      wt_hit_q[0]  <= wt_hit_d0;
      for (int i = 1; i < cbuf_rd_latency - cbuf_merge_stages; i++) begin
        dat_hit_q[i] <= dat_hit_q[i-1];
        wt_hit_q[i]  <= wt_hit_q[i-1];
      end
    end
  end

  assign dat_hit = dat_hit_q[cbuf_rd_latency-cbuf_merge_stages-1];
  assign wt_hit  = wt_hit_q[cbuf_rd_latency-cbuf_merge_stages-1];

endmodule

// ==== verilog/cbuf_read_merge.sv ====
// ===================================================================
// convolution buffer read merge
// masks bank outputs by hit, four-level or-tree, retimed valid
// ===================================================================
module cbuf_read_merge
  import cbuf_pkg::*;
(
  input  logic            nvdla_core_clk,
  input  logic            rst,
  input  cbuf_word_t      bank_data [cbuf_bank_num],
  input  cbuf_bank_mask_t hit,
  output cbuf_rd_rsp_t    rsp
);

  // level 1, one masked word per bank
  cbuf_word_t l1_data [cbuf_bank_num];
  // level 2, one node per group of fanin banks
  cbuf_word_t l2_data_w [cbuf_bank_num/cbuf_merge_fanin];
  cbuf_word_t l2_data [cbuf_bank_num/cbuf_merge_fanin];
  // level 3, single node over the level 2 groups
  cbuf_word_t l3_data_w;
  cbuf_word_t l3_data;
  // level 4, output register
  cbuf_word_t l4_data;
  // valid delay line, one stage per tree level
  logic       vld_q [cbuf_merge_stages];

  // ===================================================================
  // level 1
  // ===================================================================
  // banks not hit by this port contribute zero to the or-tree
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_bank_num; b++) begin
      l1_data[b] <= bank_data[b] & {cbuf_word_bits{hit[b]}};
    end
  end

  // ===================================================================
  // level 2
  // ===================================================================
  always_comb begin
    for (int g = 0; g < cbuf_bank_num / cbuf_merge_fanin; g++) begin
      l2_data_w[g] = '0;
      for (int i = 0; i < cbuf_merge_fanin; i++) begin
        l2_data_w[g] = l2_data_w[g] | l1_data[g*cbuf_merge_fanin+i];
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int g = 0; g < cbuf_bank_num / cbuf_merge_fanin; g++) begin
      l2_data[g] <= l2_data_w[g];
    end
  end

  // ===================================================================
  // level 3 and 4
  // ===================================================================
  always_comb begin
    l3_data_w = '0;
    for (int g = 0; g < cbuf_bank_num / cbuf_merge_fanin; g++) begin
      l3_data_w = l3_data_w | l2_data[g];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    l3_data <= l3_data_w;
    // final register only for timing, no logic in front
    l4_data <= l3_data;
  end

  // ===================================================================
  // valid
  // ===================================================================
  // any hit means one response word, same depth as the data tree
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      for (int i = 0; i < cbuf_merge_stages; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= |hit;
      for (int i = 1; i < cbuf_merge_stages; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_comb begin
    rsp.valid = vld_q[cbuf_merge_stages-1];
    rsp.data  = l4_data;
  end

endmodule

// ==== verilog/cbuf.sv ====
// ===================================================================
// convolution buffer top
// 16 banks shared by a data and a weight port for write and for read
// ===================================================================
module cbuf
  import cbuf_pkg::*;
(
  input  logic         nvdla_core_clk,
  input  logic         rst,
  // write port 0, feature data
  input  cbuf_wr_req_t dat_wr,
  // write port 1, weights
  input  cbuf_wr_req_t wt_wr,
  // read requests, never the same bank in one cycle
  input  cbuf_rd_req_t dat_rd,
  input  cbuf_rd_req_t wt_rd,
  // read responses, fixed latency after the request
  output cbuf_rd_rsp_t dat_rsp,
  output cbuf_rd_rsp_t wt_rsp
);

  // ram side controls, one entry per bank
  cbuf_ram_wr_t    ram_wr [cbuf_bank_num];
  cbuf_ram_rd_t    ram_rd [cbuf_bank_num];
  // registered ram outputs
  cbuf_word_t      bank_data [cbuf_bank_num];
  // per-port hits, aligned to bank_data
  cbuf_bank_mask_t dat_hit;
  cbuf_bank_mask_t wt_hit;

  // ===================================================================
  // write side
  // ===================================================================
  cbuf_write_path write_path_i (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dat_wr         (dat_wr),
    .wt_wr          (wt_wr),
    .ram_wr         (ram_wr)
  );

  // ===================================================================
  // read request side
  // ===================================================================
  cbuf_read_decode read_decode_i (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dat_rd         (dat_rd),
    .wt_rd          (wt_rd),
    .ram_rd         (ram_rd),
    .dat_hit        (dat_hit),
    .wt_hit         (wt_hit)
  );

  // ===================================================================
  // bank storage
  // ===================================================================
  // one ram per bank, row from the low address bits
  for (genvar b = 0; b < cbuf_bank_num; b++) begin : g_bank
    cbuf_bank_ram bank_ram_i (
      .nvdla_core_clk (nvdla_core_clk),
      .wr             (ram_wr[b]),
      .rd             (ram_rd[b]),
      .rd_data        (bank_data[b])
    );
  end

  // ===================================================================
  // read response side
  // ===================================================================
  // data port merge
  cbuf_read_merge dat_merge_i (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .bank_data      (bank_data),
    .hit            (dat_hit),
    .rsp            (dat_rsp)
  );

  // weight port merge, same tree on the weight hits
  cbuf_read_merge wt_merge_i (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .bank_data      (bank_data),
    .hit            (wt_hit),
    .rsp            (wt_rsp)
  );

endmodule

// ==== bench/cbuf_tb.sv ====
// ===================================================================
// convolution buffer testbench
// random traffic on both write and read ports, checked against a model
// ===================================================================
module cbuf_tb
  import cbuf_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // one expected read word and the step where it must show up
  typedef struct packed {
    cbuf_word_t word;
    int         due;
  } exp_t;

  logic         nvdla_core_clk;
  logic         rst;
  cbuf_wr_req_t dat_wr;
  cbuf_wr_req_t wt_wr;
  cbuf_rd_req_t dat_rd;
  cbuf_rd_req_t wt_rd;
  cbuf_rd_rsp_t dat_rsp;
  cbuf_rd_rsp_t wt_rsp;

  // model memory over the full address space
  cbuf_word_t   model_mem [2**cbuf_addr_bits];
  // writes of the last two steps, not yet visible to reads
  cbuf_wr_req_t pend_dat [2];
  cbuf_wr_req_t pend_wt [2];
  exp_t         dat_q [$];
  exp_t         wt_q [$];
  logic [31:0]  rand_state;
  int           step_n;
  int           err_count;
  int           test_errs;
  int           tests_ok;
  int           tests_bad;
  bit           timed_out;
  string        test_name;

  cbuf dut_i (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dat_wr         (dat_wr),
    .wt_wr          (wt_wr),
    .dat_rd         (dat_rd),
    .wt_rd          (wt_rd),
    .dat_rsp        (dat_rsp),
    .wt_rsp         (wt_rsp)
  );

  // 40 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  // reset over the first 5 rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (5) @(negedge nvdla_core_clk);
    rst = 1'b0;
  end

  // ===================================================================
  // helpers
  // ===================================================================
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // bank index lives in the upper address bits
  function automatic cbuf_bank_t bank_of(cbuf_addr_t a);
    return a[cbuf_addr_bits-1 -: cbuf_bank_bits];
  endfunction

  // every byte of the word depends on all address bits
  function automatic cbuf_word_t fill_word(cbuf_addr_t a);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  task automatic check_rsp_valid(string port, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s %s valid expected %b actual %b", test_name, port, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(string port, cbuf_word_t exp, cbuf_word_t act);
    if (act !== exp) begin
      $display("ERR %s %s data expected %h actual %h", test_name, port, exp, act);
      err_count++;
    end
  endtask

  // outputs are stable at the falling edge
  task automatic check_outputs();
    logic dat_exp;
    logic wt_exp;
    dat_exp = (dat_q.size() > 0) && (dat_q[0].due == step_n);
    wt_exp  = (wt_q.size() > 0) && (wt_q[0].due == step_n);
    check_rsp_valid("dat", dat_exp, dat_rsp.valid);
    check_rsp_valid("wt", wt_exp, wt_rsp.valid);
    if (dat_exp) begin
      check_word("dat", dat_q[0].word, dat_rsp.data);
      dat_q.delete(0);
    end
    if (wt_exp) begin
      check_word("wt", wt_q[0].word, wt_rsp.data);
      wt_q.delete(0);
    end
  endtask

  // a read sampled at edge m sees writes sampled at edge m-2 or earlier
  task automatic update_model(cbuf_wr_req_t dw, cbuf_wr_req_t tw,
                              cbuf_rd_req_t dr, cbuf_rd_req_t tr);
    exp_t e;
    if (pend_dat[1].en) model_mem[pend_dat[1].addr] = pend_dat[1].data;
    if (pend_wt[1].en) model_mem[pend_wt[1].addr] = pend_wt[1].data;
    // six register stages to the response, seen at the falling edge after the last one
    e.due = step_n + cbuf_rd_latency;
    if (dr.en) begin
      e.word = model_mem[dr.addr];
      dat_q.push_back(e);
    end
    if (tr.en) begin
      e.word = model_mem[tr.addr];
      wt_q.push_back(e);
    end
    pend_dat[1] = pend_dat[0];
    pend_wt[1]  = pend_wt[0];
    pend_dat[0] = dw;
    pend_wt[0]  = tw;
    // data port wins a shared bank
    if (dw.en && tw.en && bank_of(dw.addr) == bank_of(tw.addr)) pend_wt[0].en = 1'b0;
  endtask

  // one clock step, check then drive on the falling edge
  task automatic run_cycle(cbuf_wr_req_t dw, cbuf_wr_req_t tw,
                           cbuf_rd_req_t dr, cbuf_rd_req_t tr);
    @(negedge nvdla_core_clk);
    step_n++;
    check_outputs();
    update_model(dw, tw, dr, tr);
    dat_wr = dw;
    wt_wr  = tw;
    dat_rd = dr;
    wt_rd  = tr;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(posedge nvdla_core_clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("reset was not released within %0d cycles", n);
      timed_out = 1'b1;
    end
  endtask

  // idle until every read in flight has answered
  task automatic drain();
    int n;
    n = 0;
    while ((dat_q.size() > 0 || wt_q.size() > 0) && n < 20) begin
      run_cycle('0, '0, '0, '0);
      n++;
    end
    if (dat_q.size() > 0 || wt_q.size() > 0) begin
      $display("%s: reads still outstanding after %0d idle cycles", test_name, n);
      timed_out = 1'b1;
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    drain();
    if (err_count == test_errs && !timed_out) begin
      tests_ok++;
      $display("test %-12s ok", test_name);
    end else begin
      tests_bad++;
      $display("test %-12s failed, %0d errors", test_name, err_count - test_errs);
    end
  endtask

  // ===================================================================
  // tests
  // ===================================================================
  // lower half through the data port, upper half through the weight port
  task automatic test_fill();
    cbuf_wr_req_t dw;
    cbuf_wr_req_t tw;
    start_test("fill");
    for (int i = 0; i < 128; i++) begin
      dw.en   = 1'b1;
      dw.addr = cbuf_addr_t'(i);
      dw.data = fill_word(dw.addr);
      tw.en   = 1'b1;
      tw.addr = cbuf_addr_t'(i + 128);
      tw.data = fill_word(tw.addr);
      run_cycle(dw, tw, '0, '0);
    end
    end_test();
  endtask

  // back to back on both ports, banks always 8 apart
  task automatic test_readback();
    cbuf_rd_req_t dr;
    cbuf_rd_req_t tr;
    start_test("readback");
    for (int i = 0; i < 256; i++) begin
      dr.en   = 1'b1;
      dr.addr = cbuf_addr_t'(i);
      tr.en   = 1'b1;
      tr.addr = cbuf_addr_t'(i) ^ 8'h80;
      run_cycle('0, '0, dr, tr);
    end
    end_test();
  endtask

  // both writes to one bank, different rows
  task automatic test_conflict();
    cbuf_wr_req_t dw;
    cbuf_wr_req_t tw;
    cbuf_rd_req_t dr;
    cbuf_rd_req_t tr;
    logic [31:0]  r;
    start_test("conflict");
    for (int i = 0; i < 32; i++) begin
      r       = next_rand();
      dw.en   = 1'b1;
      dw.addr = r[7:0];
      dw.data = next_rand();
      tw.en   = 1'b1;
      tw.addr = {r[7:4], r[3:0] ^ (r[11:8] | 4'h1)};
      tw.data = next_rand();
      run_cycle(dw, tw, '0, '0);
      run_cycle('0, '0, '0, '0);
      dr.en   = 1'b1;
      dr.addr = dw.addr;
      run_cycle('0, '0, dr, '0);
      tr.en   = 1'b1;
      tr.addr = tw.addr;
      run_cycle('0, '0, '0, tr);
    end
    end_test();
  endtask

  // read one step after a write gets old data, two steps after gets new
  task automatic test_visibility();
    cbuf_wr_req_t w;
    cbuf_rd_req_t dr;
    cbuf_rd_req_t tr;
    logic [31:0]  r;
    start_test("visibility");
    for (int i = 0; i < 16; i++) begin
      r       = next_rand();
      w.en    = 1'b1;
      w.addr  = r[7:0];
      w.data  = ~model_mem[w.addr];
      if (i[0]) run_cycle('0, w, '0, '0);
      else run_cycle(w, '0, '0, '0);
      dr.en   = 1'b1;
      dr.addr = w.addr;
      run_cycle('0, '0, dr, '0);
      tr.en   = 1'b1;
      tr.addr = w.addr;
      run_cycle('0, '0, '0, tr);
      run_cycle('0, '0, '0, '0);
      run_cycle('0, '0, '0, '0);
    end
    end_test();
  endtask

  // mixed random traffic, read banks kept apart
  task automatic test_stream();
    cbuf_wr_req_t dw;
    cbuf_wr_req_t tw;
    cbuf_rd_req_t dr;
    cbuf_rd_req_t tr;
    logic [31:0]  r1;
    logic [31:0]  r2;
    start_test("stream");
    for (int i = 0; i < 400; i++) begin
      r1      = next_rand();
      r2      = next_rand();
      dw.en   = r1[31];
      dw.addr = r1[23:16];
      dw.data = next_rand();
      tw.en   = r1[30];
      tw.addr = r1[15:8];
      tw.data = next_rand();
      dr.en   = r1[29] | r1[27];
      dr.addr = r2[23:16];
      tr.en   = r1[28] | r1[26];
      tr.addr = r2[15:8];
      if (dr.en && tr.en && bank_of(dr.addr) == bank_of(tr.addr)) begin
        tr.addr[7:4] = dr.addr[7:4] + {1'b0, r2[2:0]} + 4'd1;
      end
      run_cycle(dw, tw, dr, tr);
    end
    end_test();
  endtask

  // ===================================================================
  // main sequence
  // ===================================================================
  initial begin
    dat_wr      = '0;
    wt_wr       = '0;
    dat_rd      = '0;
    wt_rd       = '0;
    pend_dat[0] = '0;
    pend_dat[1] = '0;
    pend_wt[0]  = '0;
    pend_wt[1]  = '0;
    rand_state  = 32'h3563;
    step_n      = 0;
    err_count   = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    timed_out   = 1'b0;
    test_name   = "reset";
    wait_reset();
    if (!timed_out) test_fill();
    if (!timed_out) test_readback();
    if (!timed_out) test_conflict();
    if (!timed_out) test_visibility();
    if (!timed_out) test_stream();
    $display("tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, err_count);
    if (err_count == 0 && tests_bad == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
verilog/cbuf_pkg.sv
verilog/cbuf_bank_ram.sv
verilog/cbuf_write_path.sv
verilog/cbuf_read_decode.sv
verilog/cbuf_read_merge.sv
verilog/cbuf.sv
bench/cbuf_tb.sv
